/* src/plic_macros.svh */
`ifndef PLIC_MACROS_SVH
`define PLIC_MACROS_SVH

// source count and field widths
`define PLIC_NUM_SOURCES 16
`define PLIC_ID_WIDTH    4   // log2 of the source count
`define PLIC_PRIO_WIDTH  8
`define PLIC_ADDR_WIDTH  12
`define PLIC_DATA_WIDTH  32
`define PLIC_STRB_WIDTH  4   // one strobe per data byte

// pipeline depths
`define PLIC_TREE_LEVELS 4   // log2 of the source count, one flop stage each
`define PLIC_SYNC_STAGES 2

// register map, byte addresses
`define PLIC_EN_ADDR   12'h000  // enable word, bit i is source i
`define PLIC_PRI_ADDR  12'h100  // priority bytes, four sources per word
`define PLIC_ID_ADDR   12'h200  // current winner id
`define PLIC_MVEC_ADDR 12'h204  // winner's handler vector
`define PLIC_MARG_ADDR 12'h208  // winner's argument
`define PLIC_VEC_ADDR  12'h400  // vector table, one word per source
`define PLIC_OBJ_ADDR  12'h800  // object table, one word per source

// table bases are aligned to the table size,
// so the low word address bits index the entry directly

`endif

/* src/plic_pkg.sv */
`include "plic_macros.svh"

package plic_pkg;

    // source id, 0 to NUM_SOURCES-1
    typedef logic [`PLIC_ID_WIDTH-1:0] src_id_t;

    // priority, zero means the source never wins
    typedef logic [`PLIC_PRIO_WIDTH-1:0] prio_t;

    // bus data word
    typedef logic [`PLIC_DATA_WIDTH-1:0] word_t;

    // bus byte address
    typedef logic [`PLIC_ADDR_WIDTH-1:0] addr_t;

    // one arbitration candidate, emitted by a gateway and carried by each tree node
    typedef struct packed {
        logic    pending;  // qualified request
        prio_t   prio;
        src_id_t id;
    } irq_req_t;

endpackage

/* src/plic_regs.sv */
`timescale 1ns/1ps
`include "plic_macros.svh"

module plic_regs (
    input  logic                                      clk,
    input  logic                                      rst_n,

    // write side, commits on the rising edge while wen is high
    input  plic_pkg::addr_t                           waddr,
    input  plic_pkg::word_t                           wdata,
    input  logic [`PLIC_STRB_WIDTH-1:0]               wstrb,
    input  logic                                      wen,

    // read side, combinational
    input  plic_pkg::addr_t                           raddr,
    output plic_pkg::word_t                           rdata,

    // per-source configuration towards the gateways
    output logic [`PLIC_NUM_SOURCES-1:0]              int_en,
    output plic_pkg::prio_t [`PLIC_NUM_SOURCES-1:0]   int_pri,

    // arbitration result from the tree
    input  plic_pkg::irq_req_t                        winner,
    output logic                                      irq_valid
);

    plic_pkg::word_t   vec_tab [`PLIC_NUM_SOURCES];  // handler entry addresses
    plic_pkg::word_t   obj_tab [`PLIC_NUM_SOURCES];  // handler arguments

    plic_pkg::src_id_t irq_id;  // registered winner id
    plic_pkg::word_t   mvec;    // vector of irq_id, one cycle behind
    plic_pkg::word_t   marg;    // argument of irq_id, one cycle behind

    // true when the word address of a falls inside [base, base + words)
    function automatic logic hit_words(input plic_pkg::addr_t a, input plic_pkg::addr_t base,
                                       input int words);
        logic [`PLIC_ADDR_WIDTH-3:0] wa;
        logic [`PLIC_ADDR_WIDTH-3:0] wb;
        wa = a[`PLIC_ADDR_WIDTH-1:2];
        wb = base[`PLIC_ADDR_WIDTH-1:2];
        return (wa >= wb) && (int'(wa) < int'(wb) + words);
    endfunction

    // source owning byte lane of a priority word
    function automatic plic_pkg::src_id_t pri_src(input plic_pkg::addr_t a,
                                                  input logic [1:0] lane);
        return {a[2 +: `PLIC_ID_WIDTH-2], lane};
    endfunction

    // entry index within a word table
    function automatic plic_pkg::src_id_t tab_idx(input plic_pkg::addr_t a);
        return a[2 +: `PLIC_ID_WIDTH];
    endfunction

    // configuration and table writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_en  <= '0;
            int_pri <= '0;
            for (int i = 0; i < `PLIC_NUM_SOURCES; i++) begin
                vec_tab[i] <= '0;
                obj_tab[i] <= '0;
            end
        end else if (wen) begin
            if (waddr == `PLIC_EN_ADDR) begin
                for (int i = 0; i < `PLIC_NUM_SOURCES; i++) begin
                    if (wstrb[i/8]) begin  // byte strobe covers eight enable bits
                        int_en[i] <= wdata[i];
                    end
                end
            end else if (hit_words(waddr, `PLIC_PRI_ADDR, `PLIC_NUM_SOURCES/4)) begin
                for (int lane = 0; lane < `PLIC_STRB_WIDTH; lane++) begin
                    if (wstrb[lane]) begin
                        int_pri[pri_src(waddr, 2'(lane))] <= wdata[lane*8 +: 8];
                    end
                end
            end else if (hit_words(waddr, `PLIC_VEC_ADDR, `PLIC_NUM_SOURCES)) begin
                vec_tab[tab_idx(waddr)] <= wdata;  // whole word, strobes ignored
            end else if (hit_words(waddr, `PLIC_OBJ_ADDR, `PLIC_NUM_SOURCES)) begin
                obj_tab[tab_idx(waddr)] <= wdata;
            end
        end
    end

    // winner capture, then table lookup on the captured id
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_valid <= 1'b0;
            irq_id    <= '0;
            mvec      <= '0;
            marg      <= '0;
        end else begin
            irq_valid <= winner.pending;
            irq_id    <= winner.id;  // tree forces zero when nothing pends
            if (irq_valid) begin
                mvec <= vec_tab[irq_id];
                marg <= obj_tab[irq_id];
            end
        end
    end

    // read mux
    always_comb begin
        rdata = '0;
        if (raddr == `PLIC_EN_ADDR) begin
            rdata = plic_pkg::word_t'(int_en);
        end else if (hit_words(raddr, `PLIC_PRI_ADDR, `PLIC_NUM_SOURCES/4)) begin
            for (int lane = 0; lane < `PLIC_STRB_WIDTH; lane++) begin
                rdata[lane*8 +: 8] = int_pri[pri_src(raddr, 2'(lane))];
            end
        end else if (raddr == `PLIC_ID_ADDR) begin
            rdata = plic_pkg::word_t'(irq_id);
        end else if (raddr == `PLIC_MVEC_ADDR) begin
            rdata = mvec;
        end else if (raddr == `PLIC_MARG_ADDR) begin
            rdata = marg;
        end else if (hit_words(raddr, `PLIC_VEC_ADDR, `PLIC_NUM_SOURCES)) begin
            rdata = vec_tab[tab_idx(raddr)];
        end else if (hit_words(raddr, `PLIC_OBJ_ADDR, `PLIC_NUM_SOURCES)) begin
            rdata = obj_tab[tab_idx(raddr)];
        end
    end

endmodule

/* src/plic_gateway.sv */
`timescale 1ns/1ps
`include "plic_macros.svh"

module plic_gateway (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               irq_src,  // asynchronous level
    input  logic               enable,
    input  plic_pkg::prio_t    pri,
    input  plic_pkg::src_id_t  id,
    output plic_pkg::irq_req_t req
);

    logic [`PLIC_SYNC_STAGES-1:0] sync_q;
    logic                         src_level;
    logic                         pending;

    // synchronizer chain, bit 0 samples the raw input
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[`PLIC_SYNC_STAGES-2:0], irq_src};
        end
    end

    assign src_level = sync_q[`PLIC_SYNC_STAGES-1];

    // priority zero never competes
    assign pending = src_level & enable & (pri != '0);

    assign req = '{pending: pending, prio: pri, id: id};

endmodule

/* src/plic_priority_tree.sv */
`timescale 1ns/1ps
`include "plic_macros.svh"

module plic_priority_tree (
    input  logic               clk,
    input  logic               rst_n,
    input  plic_pkg::irq_req_t req_in [`PLIC_NUM_SOURCES],
    output plic_pkg::irq_req_t winner
);

    // registered tree nodes in heap order
    // node 0 is the root, children of k sit at 2k+1 and 2k+2
    // the leaves are req_in and are not stored here
    plic_pkg::irq_req_t node_q [`PLIC_NUM_SOURCES-1];

    // pairwise compare, a is the lower-id operand
    function automatic plic_pkg::irq_req_t pick(input plic_pkg::irq_req_t a,
                                                input plic_pkg::irq_req_t b);
        plic_pkg::irq_req_t res;
        res = '0;  // nothing pending gives zero prio and id
        if (a.pending && (!b.pending || a.prio >= b.prio)) begin
            res = a;  // ties stay on the left
        end else if (b.pending) begin
            res = b;
        end
        return res;
    endfunction

    for (genvar lvl = 0; lvl < `PLIC_TREE_LEVELS; lvl++) begin : g_level
        // level 0 compares leaf pairs, the last level is the root
        localparam int NODES = `PLIC_NUM_SOURCES >> (lvl + 1);
        localparam int BASE  = NODES - 1;

        for (genvar j = 0; j < NODES; j++) begin : g_node
            localparam int K = BASE + j;

            plic_pkg::irq_req_t lhs;
            plic_pkg::irq_req_t rhs;

            if (lvl == 0) begin : g_leaf
                assign lhs = req_in[2*j];
                assign rhs = req_in[2*j+1];
            end else begin : g_inner
                assign lhs = node_q[2*K+1];
                assign rhs = node_q[2*K+2];
            end

            // one register stage per level
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    node_q[K] <= '0;
                end else begin
                    node_q[K] <= pick(lhs, rhs);
                end
            end
        end
    end

    assign winner = node_q[0];

endmodule

/* src/plic_top.sv */
`timescale 1ns/1ps
`include "plic_macros.svh"

module plic_top (
    input  logic                         clk,
    input  logic                         rst_n,

    // register write port
    input  plic_pkg::addr_t              waddr,
    input  plic_pkg::word_t              wdata,
    input  logic [`PLIC_STRB_WIDTH-1:0]  wstrb,
    input  logic                         wen,

    // register read port
    input  plic_pkg::addr_t              raddr,
    output plic_pkg::word_t              rdata,

    // external level sources
    input  logic [`PLIC_NUM_SOURCES-1:0] irq_sources,

    output logic                         irq_valid
);

    logic [`PLIC_NUM_SOURCES-1:0]            int_en;
    plic_pkg::prio_t [`PLIC_NUM_SOURCES-1:0] int_pri;
    plic_pkg::irq_req_t                      req [`PLIC_NUM_SOURCES];  // gateway outputs
    plic_pkg::irq_req_t                      winner;

    plic_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .waddr     (waddr),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wen       (wen),
        .raddr     (raddr),
        .rdata     (rdata),
        .int_en    (int_en),
        .int_pri   (int_pri),
        .winner    (winner),
        .irq_valid (irq_valid)
    );

    // one gateway per source, id is the slot index
    for (genvar i = 0; i < `PLIC_NUM_SOURCES; i++) begin : g_gateway
        plic_gateway u_gateway (
            .clk     (clk),
            .rst_n   (rst_n),
            .irq_src (irq_sources[i]),
            .enable  (int_en[i]),
            .pri     (int_pri[i]),
            .id      (plic_pkg::src_id_t'(i)),
            .req     (req[i])
        );
    end

    plic_priority_tree u_tree (
        .clk    (clk),
        .rst_n  (rst_n),
        .req_in (req),
        .winner (winner)
    );

endmodule

/* verif/plic_tb.sv */
`timescale 1ns/1ps
`include "plic_macros.svh"

module plic_tb;

    logic                                clk;
    logic                                rst_n;
    plic_pkg::addr_t                     waddr;
    plic_pkg::word_t                     wdata;
    logic [`PLIC_STRB_WIDTH-1:0]         wstrb;
    logic                                wen;
    plic_pkg::addr_t                     raddr;
    plic_pkg::word_t                     rdata;
    logic [`PLIC_NUM_SOURCES-1:0]        irq_sources;
    logic                                irq_valid;

    integer seed;

    // shadow copies of the register block
    logic [`PLIC_NUM_SOURCES-1:0] sh_en;
    logic [7:0]                   sh_pri [`PLIC_NUM_SOURCES];
    logic [31:0]                  sh_vec [`PLIC_NUM_SOURCES];
    logic [31:0]                  sh_obj [`PLIC_NUM_SOURCES];
    logic [31:0]                  last_mvec;  // vector of the last seen winner
    logic [31:0]                  last_marg;

    plic_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .waddr       (waddr),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wen         (wen),
        .raddr       (raddr),
        .rdata       (rdata),
        .irq_sources (irq_sources),
        .irq_valid   (irq_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act);
            $display("Result: FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic drive_write(input plic_pkg::addr_t a, input plic_pkg::word_t d,
                               input logic [3:0] s);
        @(negedge clk);
        waddr = a;
        wdata = d;
        wstrb = s;
        wen   = 1'b1;
        @(negedge clk);  // committed at the rising edge in between
        wen   = 1'b0;
    endtask

    task automatic read_reg(input plic_pkg::addr_t a, output plic_pkg::word_t d);
        @(negedge clk);
        raddr = a;
        #1 d = rdata;  // combinational read sampled mid low phase
    endtask

    // fixed wait longer than the 8-cycle worst case
    task automatic settle();
        repeat (9) @(negedge clk);
    endtask

    task automatic wait_irq_valid(input int limit);
        int n;
        n = 0;
        while (irq_valid !== 1'b1) begin
            if (n == limit) begin
                $display("timeout: irq_valid did not rise within %0d cycles", limit);
                $display("Result: FAILED");
                $fatal(1, "timeout waiting for irq_valid");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic set_enables(input logic [31:0] d, input logic [3:0] s);
        for (int i = 0; i < `PLIC_NUM_SOURCES; i++) begin
            if (s[i/8]) sh_en[i] = d[i];  // eight enable bits per strobe
        end
        drive_write(`PLIC_EN_ADDR, d, s);
    endtask

    task automatic set_priority_word(input int w, input logic [31:0] d, input logic [3:0] s);
        for (int lane = 0; lane < 4; lane++) begin
            if (s[lane]) sh_pri[w*4+lane] = d[lane*8 +: 8];
        end
        drive_write(plic_pkg::addr_t'(`PLIC_PRI_ADDR + 4*w), d, s);
    endtask

    // tables ignore the strobes
    task automatic set_vector(input int i, input logic [31:0] d, input logic [3:0] s);
        sh_vec[i] = d;
        drive_write(plic_pkg::addr_t'(`PLIC_VEC_ADDR + 4*i), d, s);
    endtask

    task automatic set_object(input int i, input logic [31:0] d, input logic [3:0] s);
        sh_obj[i] = d;
        drive_write(plic_pkg::addr_t'(`PLIC_OBJ_ADDR + 4*i), d, s);
    endtask

    function automatic logic [31:0] pri_word(input int w);
        return {sh_pri[w*4+3], sh_pri[w*4+2], sh_pri[w*4+1], sh_pri[w*4]};
    endfunction

    // small set of levels so that ties and zeros show up often
    function automatic logic [31:0] tie_prone_prios();
        logic [31:0] d;
        for (int lane = 0; lane < 4; lane++) begin
            d[lane*8 +: 8] = 8'(($random(seed) & 3) * 8'h40);
        end
        return d;
    endfunction

    function automatic logic is_mapped(input plic_pkg::addr_t a);
        return a == `PLIC_EN_ADDR || a == `PLIC_ID_ADDR || a == `PLIC_MVEC_ADDR
            || a == `PLIC_MARG_ADDR
            || (a >= `PLIC_PRI_ADDR && a < `PLIC_PRI_ADDR + 16)
            || (a >= `PLIC_VEC_ADDR && a < `PLIC_VEC_ADDR + 64)
            || (a >= `PLIC_OBJ_ADDR && a < `PLIC_OBJ_ADDR + 64);
    endfunction

    // highest priority among qualifying sources
    // strict compare keeps the lower id on ties
    function automatic void expected_winner(input logic [15:0] srcs, output logic found,
                                            output logic [3:0] id);
        logic [7:0] best;
        found = 1'b0;
        id    = '0;
        best  = '0;
        for (int i = 0; i < `PLIC_NUM_SOURCES; i++) begin
            if (srcs[i] && sh_en[i] && sh_pri[i] != 0 && (!found || sh_pri[i] > best)) begin
                found = 1'b1;
                id    = 4'(i);
                best  = sh_pri[i];
            end
        end
    endfunction

    task automatic check_config_readback();
        plic_pkg::word_t d;
        read_reg(`PLIC_EN_ADDR, d);
        compare("int_en", {16'h0, sh_en}, d);
        for (int w = 0; w < `PLIC_NUM_SOURCES/4; w++) begin
            read_reg(plic_pkg::addr_t'(`PLIC_PRI_ADDR + 4*w), d);
            compare($sformatf("pri_word[%0d]", w), pri_word(w), d);
        end
        for (int i = 0; i < `PLIC_NUM_SOURCES; i++) begin
            read_reg(plic_pkg::addr_t'(`PLIC_VEC_ADDR + 4*i), d);
            compare($sformatf("vec_tab[%0d]", i), sh_vec[i], d);
            read_reg(plic_pkg::addr_t'(`PLIC_OBJ_ADDR + 4*i), d);
            compare($sformatf("obj_tab[%0d]", i), sh_obj[i], d);
        end
    endtask

    task automatic check_arbitration();
        logic            found;
        logic [3:0]      win;
        plic_pkg::word_t d;
        expected_winner(irq_sources, found, win);
        compare("irq_valid", found, irq_valid);
        read_reg(`PLIC_ID_ADDR, d);
        if (irq_valid) begin
            // granted source must be enabled with a nonzero priority
            compare("winner enable", 1'b1, sh_en[d[3:0]]);
            compare("winner prio nonzero", 1'b1, sh_pri[d[3:0]] != 0);
        end
        compare("irq_id", found ? win : 4'h0, d);
        if (found) begin
            last_mvec = sh_vec[win];
            last_marg = sh_obj[win];
        end
        read_reg(`PLIC_MVEC_ADDR, d);
        compare("mvec", last_mvec, d);
        read_reg(`PLIC_MARG_ADDR, d);
        compare("marg", last_marg, d);
    endtask

    initial begin
        plic_pkg::word_t d;
        plic_pkg::addr_t a;
        logic [31:0]     data;
        logic [3:0]      strb;
        int              op;
        int              idx;
        int              k;

        seed        = 32'he807_da10;
        rst_n       = 1'b0;
        waddr       = '0;
        wdata       = '0;
        wstrb       = '0;
        wen         = 1'b0;
        raddr       = '0;
        irq_sources = '0;
        sh_en       = '0;
        last_mvec   = '0;
        last_marg   = '0;
        for (int i = 0; i < `PLIC_NUM_SOURCES; i++) begin
            sh_pri[i] = '0;
            sh_vec[i] = '0;
            sh_obj[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // everything reads zero after reset
        compare("irq_valid after reset", 1'b0, irq_valid);
        check_config_readback();
        check_arbitration();

        // random register traffic with read-back of the touched word
        for (int n = 0; n < 60; n++) begin
            op   = $random(seed) & 3;
            data = $random(seed);
            strb = $random(seed);
            idx  = $random(seed) & 15;
            case (op)
                0: begin
                    set_enables(data, strb);
                    read_reg(`PLIC_EN_ADDR, d);
                    compare("int_en", {16'h0, sh_en}, d);
                end
                1: begin
                    set_priority_word(idx & 3, data, strb);
                    read_reg(plic_pkg::addr_t'(`PLIC_PRI_ADDR + 4*(idx & 3)), d);
                    compare($sformatf("pri_word[%0d]", idx & 3), pri_word(idx & 3), d);
                end
                2: begin
                    set_vector(idx, data, strb);
                    read_reg(plic_pkg::addr_t'(`PLIC_VEC_ADDR + 4*idx), d);
                    compare($sformatf("vec_tab[%0d]", idx), sh_vec[idx], d);
                end
                default: begin
                    set_object(idx, data, strb);
                    read_reg(plic_pkg::addr_t'(`PLIC_OBJ_ADDR + 4*idx), d);
                    compare($sformatf("obj_tab[%0d]", idx), sh_obj[idx], d);
                end
            endcase
        end
        check_config_readback();

        // unmapped word addresses
        for (int n = 0; n < 24; n++) begin
            a = plic_pkg::addr_t'($random(seed)) & 12'hffc;
            if (!is_mapped(a)) begin
                read_reg(a, d);
                compare($sformatf("unmapped 0x%03h", a), 32'h0, d);
            end
        end

        // arbitration with config changes only while all sources are low
        for (int t = 0; t < 40; t++) begin
            @(negedge clk);
            irq_sources = '0;
            settle();
            check_arbitration();  // nothing pending so mvec and marg hold the last winner
            set_enables($random(seed), 4'b0011);
            for (int w = 0; w < `PLIC_NUM_SOURCES/4; w++) begin
                set_priority_word(w, tie_prone_prios(), 4'($random(seed)));
            end
            @(negedge clk);
            irq_sources = 16'($random(seed));
            settle();
            check_arbitration();
        end

        // table rewrite under a held source
        k = $random(seed) & 15;
        @(negedge clk);
        irq_sources = '0;
        settle();
        set_enables($random(seed) | (32'h1 << k), 4'b0011);
        set_priority_word(k / 4, {4{8'h55}}, 4'(1 << (k % 4)));
        @(negedge clk);
        irq_sources = 16'(1 << k);
        wait_irq_valid(20);
        settle();
        check_arbitration();
        set_vector(k, $random(seed), 4'($random(seed)));
        set_object(k, $random(seed), 4'($random(seed)));
        settle();
        check_arbitration();

        // source to irq_valid latency
        @(negedge clk);
        irq_sources = '0;
        settle();
        compare("irq_valid before raise", 1'b0, irq_valid);
        @(negedge clk);
        irq_sources = 16'(1 << k);
        for (int c = 1; c <= 7; c++) begin
            @(negedge clk);
            compare($sformatf("irq_valid cycle %0d", c), c == 7, irq_valid);
        end
        settle();
        check_arbitration();

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+src
src/plic_pkg.sv
src/plic_regs.sv
src/plic_gateway.sv
src/plic_priority_tree.sv
src/plic_top.sv
verif/plic_tb.sv

/* Bender.yml */
package:
  name: plic

sources:
  - include_dirs:
      - src
    files:
      - src/plic_pkg.sv
      - src/plic_regs.sv
      - src/plic_gateway.sv
      - src/plic_priority_tree.sv
      - src/plic_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/plic_tb.sv
